// File: hdl/jisp_pkg.sv
package jisp_pkg;

    // ##############################
    // Sizes
    // ##############################

    localparam int DW    = 8;
    localparam int MAX_X = 64;
    localparam int MAX_Y = 64;
    localparam int XW    = 6;
    localparam int YW    = 6;
    localparam int BLK   = 8;
    localparam int MCU_W = 16;

    // ##############################
    // Colour conversion
    // ##############################

    // Full-range BT.601 weights scaled by 256
    localparam int CY_R = 77;
    localparam int CY_G = 150;
    localparam int CY_B = 29;

    localparam int CB_R = 43;
    localparam int CB_G = 85;
    localparam int CB_B = 128;

    localparam int CR_R = 128;
    localparam int CR_G = 107;
    localparam int CR_B = 21;

    localparam int CHROMA_OFS = 128;

    // Block tag in MCU order, as carried on di_cnt
    typedef enum logic [2:0] {
        BLK_Y0 = 3'd0,
        BLK_Y1 = 3'd1,
        BLK_Y2 = 3'd2,
        BLK_Y3 = 3'd3,
        BLK_CB = 3'd4,
        BLK_CR = 3'd5
    } blk_e;

    typedef enum logic {
        ST_FILL  = 1'b0,
        ST_DRAIN = 1'b1
    } mcu_state_e;

endpackage

// File: hdl/pixel_stream_if.sv
`timescale 1ns/1ps

interface pixel_stream_if import jisp_pkg::*; ();

    // Components are Y, Cb, Cr at indices 0, 1, 2
    logic [DW-1:0] comp [2:0];
    logic [2:0]    valid;
    logic          hold;
    logic          frame_valid;

    // Position of the pixel currently presented
    logic [XW-1:0] pixel_count;
    logic [YW-1:0] line_count;
    logic          eof;

    modport src (
        output comp,
        output valid,
        output frame_valid,
        output pixel_count,
        output line_count,
        output eof,
        input  hold
    );

    modport snk (
        input  comp,
        input  valid,
        input  frame_valid,
        input  pixel_count,
        input  line_count,
        input  eof,
        output hold
    );

endinterface

// File: hdl/rgb2yuv.sv
`timescale 1ns/1ps

module rgb2yuv import jisp_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic [DW-1:0] rgb24 [2:0],
    input  logic          rgb24_valid,
    output logic          rgb24_hold,
    input  logic          frame_valid_in,
    pixel_stream_if.src   yuv_s
);

    // Input components are R, G, B at indices 0, 1, 2
    logic signed [17:0] r_s;
    logic signed [17:0] g_s;
    logic signed [17:0] b_s;

    logic signed [17:0] sum_y;
    logic signed [17:0] sum_cb;
    logic signed [17:0] sum_cr;
    logic               s1_valid;
    logic               s1_fv;

    logic signed [17:0] rnd_y;
    logic signed [17:0] rnd_cb;
    logic signed [17:0] rnd_cr;

    function automatic logic [DW-1:0] clamp8(input logic signed [17:0] v);
        if (v < 18'sd0)
            return '0;
        else if (v > 18'sd255)
            return '1;
        else
            return v[DW-1:0];
    endfunction

    // The whole pipeline stalls as one while downstream holds
    assign rgb24_hold = yuv_s.hold;

    assign r_s = {{(18-DW){1'b0}}, rgb24[0]};
    assign g_s = {{(18-DW){1'b0}}, rgb24[1]};
    assign b_s = {{(18-DW){1'b0}}, rgb24[2]};

    // ##############################
    // Stage one: weighted sums
    // ##############################

    always_ff @(posedge clk) begin
        if (!yuv_s.hold) begin
            sum_y  <= 18'(CY_R) * r_s + 18'(CY_G) * g_s + 18'(CY_B) * b_s;
            sum_cb <= 18'(CB_B) * b_s - 18'(CB_R) * r_s - 18'(CB_G) * g_s;
            sum_cr <= 18'(CR_R) * r_s - 18'(CR_G) * g_s - 18'(CR_B) * b_s;
        end
    end

    // ##############################
    // Stage two: round, offset, clamp
    // ##############################

    assign rnd_y  = (sum_y + 18'sd128) >>> 8;
    assign rnd_cb = ((sum_cb + 18'sd128) >>> 8) + 18'(CHROMA_OFS);
    assign rnd_cr = ((sum_cr + 18'sd128) >>> 8) + 18'(CHROMA_OFS);

    always_ff @(posedge clk) begin
        if (!yuv_s.hold) begin
            yuv_s.comp[0] <= clamp8(rnd_y);
            yuv_s.comp[1] <= clamp8(rnd_cb);
            yuv_s.comp[2] <= clamp8(rnd_cr);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid          <= 1'b0;
            s1_fv             <= 1'b0;
            yuv_s.valid       <= '0;
            yuv_s.frame_valid <= 1'b0;
        end else if (!yuv_s.hold) begin
            s1_valid          <= rgb24_valid;
            s1_fv             <= frame_valid_in;
            yuv_s.valid       <= {3{s1_valid}};
            yuv_s.frame_valid <= s1_fv;
        end
    end

    // Position is counted further down the chain
    assign yuv_s.pixel_count = '0;
    assign yuv_s.line_count  = '0;
    assign yuv_s.eof         = 1'b0;

endmodule

// File: hdl/subsample.sv
`timescale 1ns/1ps

module subsample import jisp_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic [XW-1:0] x_size_m1,
    input  logic [YW-1:0] y_size_m1,
    pixel_stream_if.snk   yuv_in,
    pixel_stream_if.src   yuv_out
);

    logic [XW-1:0] px;
    logic [YW-1:0] ln;
    logic          accept;
    logic          last_px;
    logic          last_ln;
    logic          even_ln;
    logic          odd_px;

    // Chroma of the even pixel waiting for its partner
    logic [DW-1:0] cb_keep;
    logic [DW-1:0] cr_keep;
    logic [DW:0]   cb_sum;
    logic [DW:0]   cr_sum;

    assign yuv_in.hold = yuv_out.hold;
    assign accept      = |yuv_in.valid && !yuv_out.hold;

    assign last_px = (px == x_size_m1);
    assign last_ln = (ln == y_size_m1);
    assign even_ln = !ln[0];
    assign odd_px  = px[0];

    // Rounded pair average
    assign cb_sum = {1'b0, cb_keep} + {1'b0, yuv_in.comp[1]} + {{DW{1'b0}}, 1'b1};
    assign cr_sum = {1'b0, cr_keep} + {{1'b0}, yuv_in.comp[2]} + {{DW{1'b0}}, 1'b1};

    // ##############################
    // Position counters
    // ##############################

    always_ff @(posedge clk) begin
        if (rst || !yuv_in.frame_valid) begin
            px <= '0;
            ln <= '0;
        end else if (accept) begin
            if (last_px) begin
                px <= '0;
                ln <= last_ln ? '0 : ln + 1'b1;
            end else begin
                px <= px + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && even_ln && !odd_px) begin
            cb_keep <= yuv_in.comp[1];
            cr_keep <= yuv_in.comp[2];
        end
    end

    // ##############################
    // Output register
    // ##############################

    always_ff @(posedge clk) begin
        if (!yuv_out.hold) begin
            yuv_out.comp[0]     <= yuv_in.comp[0];
            yuv_out.comp[1]     <= cb_sum[DW:1];
            yuv_out.comp[2]     <= cr_sum[DW:1];
            yuv_out.pixel_count <= px;
            yuv_out.line_count  <= ln;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            yuv_out.valid       <= '0;
            yuv_out.eof         <= 1'b0;
            yuv_out.frame_valid <= 1'b0;
        end else if (!yuv_out.hold) begin
            yuv_out.frame_valid <= yuv_in.frame_valid;
            if (accept) begin
                // Luma always, chroma only on the odd pixel of an even line
                yuv_out.valid <= {{2{even_ln && odd_px}}, 1'b1};
                yuv_out.eof   <= last_px && last_ln;
            end else begin
                yuv_out.valid <= '0;
                yuv_out.eof   <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/mcu_buffer.sv
`timescale 1ns/1ps

module mcu_buffer import jisp_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic [XW-1:0] x_size_m1,
    pixel_stream_if.snk   yuv_in,
    output logic [DW-1:0] di [7:0],
    output logic          di_valid,
    input  logic          di_hold,
    output blk_e          di_cnt
);

    // One 16-line stripe of luma and the matching 8 lines of chroma
    logic [DW-1:0] y_mem  [0:MCU_W*MAX_X-1];
    logic [DW-1:0] cb_mem [0:(MCU_W/2)*(MAX_X/2)-1];
    logic [DW-1:0] cr_mem [0:(MCU_W/2)*(MAX_X/2)-1];

    mcu_state_e      state;
    logic [XW-5:0]   mcu_cnt;
    blk_e            blk;
    logic [2:0]      blk_code;
    logic [2:0]      row;
    logic            issue_done;

    logic            y_wr;
    logic            c_wr;
    logic            stripe_end;
    logic            load;
    logic            last_row;
    logic [DW-1:0]   rd_row [7:0];

    // ##############################
    // Fill side
    // ##############################

    // The input is only held while the stripe drains
    assign yuv_in.hold = (state == ST_DRAIN);

    assign y_wr = yuv_in.valid[0] && (state == ST_FILL);
    assign c_wr = yuv_in.valid[1] && (state == ST_FILL);

    assign stripe_end = y_wr && (yuv_in.pixel_count == x_size_m1) &&
                        ((yuv_in.line_count[3:0] == 4'hf) || yuv_in.eof);

    always_ff @(posedge clk) begin
        if (y_wr)
            y_mem[{yuv_in.line_count[3:0], yuv_in.pixel_count}] <= yuv_in.comp[0];
        if (c_wr) begin
            cb_mem[{yuv_in.line_count[3:1], yuv_in.pixel_count[XW-1:1]}] <= yuv_in.comp[1];
            cr_mem[{yuv_in.line_count[3:1], yuv_in.pixel_count[XW-1:1]}] <= yuv_in.comp[2];
        end
    end

    // ##############################
    // Drain side
    // ##############################

    assign blk_code = blk;

    // Bit 1 of a luma tag picks the bottom half, bit 0 the right half
    always_comb begin
        for (int k = 0; k < BLK; k++) begin
            case (blk)
                BLK_CB:  rd_row[k] = cb_mem[{row, mcu_cnt, 3'(k)}];
                BLK_CR:  rd_row[k] = cr_mem[{row, mcu_cnt, 3'(k)}];
                default: rd_row[k] = y_mem[{blk_code[1], row, mcu_cnt, blk_code[0], 3'(k)}];
            endcase
        end
    end

    assign last_row = (mcu_cnt == x_size_m1[XW-1:4]) && (blk == BLK_CR) && (row == 3'd7);

    // A new row is fetched whenever the output register is free
    assign load = (state == ST_DRAIN) && !issue_done && (!di_valid || !di_hold);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_FILL;
            mcu_cnt    <= '0;
            blk        <= BLK_Y0;
            row        <= '0;
            issue_done <= 1'b0;
            di_valid   <= 1'b0;
        end else begin
            case (state)
                ST_FILL: begin
                    if (stripe_end)
                        state <= ST_DRAIN;
                end
                ST_DRAIN: begin
                    if (load) begin
                        di_valid <= 1'b1;
                        row      <= row + 1'b1;
                        if (row == 3'd7) begin
                            if (blk == BLK_CR) begin
                                blk     <= BLK_Y0;
                                mcu_cnt <= mcu_cnt + 1'b1;
                            end else begin
                                blk <= blk_e'(blk_code + 3'd1);
                            end
                        end
                        if (last_row)
                            issue_done <= 1'b1;
                    end else if (di_valid && !di_hold) begin
                        di_valid <= 1'b0;
                        // The final Cr row has left, so the stripe is free again
                        if (issue_done) begin
                            state      <= ST_FILL;
                            issue_done <= 1'b0;
                            mcu_cnt    <= '0;
                            blk        <= BLK_Y0;
                            row        <= '0;
                        end
                    end
                end
                default: state <= ST_FILL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            di     <= rd_row;
            di_cnt <= blk;
        end
    end

endmodule

// File: hdl/jisp.sv
`timescale 1ns/1ps

module jisp import jisp_pkg::*; (
    input  logic          clk,
    input  logic          rst,

    // Sensor side
    input  logic [DW-1:0] rgb24 [2:0],
    input  logic          rgb24_valid,
    output logic          rgb24_hold,
    input  logic          frame_valid_in,

    // Block rows towards the encoder
    output logic [DW-1:0] di [7:0],
    output logic          di_valid,
    input  logic          di_hold,
    output blk_e          di_cnt,

    // Frame size minus one, multiples of 16
    input  logic [XW-1:0] x_size_m1,
    input  logic [YW-1:0] y_size_m1
);

    pixel_stream_if yuv_s ();
    pixel_stream_if yuv420_s ();

    // ##############################
    // Colour conversion
    // ##############################

    rgb2yuv u_rgb2yuv (
        .clk            (clk),
        .rst            (rst),
        .rgb24          (rgb24),
        .rgb24_valid    (rgb24_valid),
        .rgb24_hold     (rgb24_hold),
        .frame_valid_in (frame_valid_in),
        .yuv_s          (yuv_s.src)
    );

    // 4:2:0 chroma and pixel position
    subsample u_subsample (
        .clk       (clk),
        .rst       (rst),
        .x_size_m1 (x_size_m1),
        .y_size_m1 (y_size_m1),
        .yuv_in    (yuv_s.snk),
        .yuv_out   (yuv420_s.src)
    );

    // Stripe buffer and MCU ordering
    mcu_buffer u_mcu_buffer (
        .clk       (clk),
        .rst       (rst),
        .x_size_m1 (x_size_m1),
        .yuv_in    (yuv420_s.snk),
        .di        (di),
        .di_valid  (di_valid),
        .di_hold   (di_hold),
        .di_cnt    (di_cnt)
    );

endmodule

// File: test/jisp_checker.sv
`timescale 1ns/1ps

module jisp_checker import jisp_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic [DW-1:0] di [7:0],
    input logic          di_valid,
    input logic          di_hold,
    input blk_e          di_cnt,
    input logic          rgb24_hold,
    input logic          frame_valid_in,
    input logic [XW-1:0] x_size_m1,
    input logic [YW-1:0] y_size_m1,
    input logic          pix_valid,
    input logic [XW-1:0] pix_x,
    input logic [YW-1:0] pix_y
);

    logic [8*DW-1:0] di_flat;
    logic            stripe_last;
    int              fail_count = 0;

    always_comb begin
        for (int k = 0; k < BLK; k++)
            di_flat[DW*k +: DW] = di[k];
    end

    // Last luma byte of a 16-line stripe reaching the buffer
    assign stripe_last = pix_valid && (pix_x == x_size_m1) && (pix_y[3:0] == 4'hf);

    // A held row keeps its bytes, its tag and its valid
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        di_valid && di_hold |=> di_valid && $stable(di_flat) && $stable(di_cnt))
    else begin
        $error("di changed while held");
        fail_count++;
    end

    reset_idle: assert property (@(posedge clk) rst |=> !di_valid)
    else begin
        $error("di_valid high right after reset");
        fail_count++;
    end

    size_ok: assert property (@(posedge clk) disable iff (rst)
        frame_valid_in |-> (x_size_m1[3:0] == 4'hf) && (y_size_m1[3:0] == 4'hf))
    else begin
        $error("frame size is not a multiple of 16");
        fail_count++;
    end

    // The sensor side is stalled only once a whole stripe has been taken
    hold_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(rgb24_hold) |-> $past(stripe_last))
    else begin
        $error("rgb24_hold rose before the stripe was complete");
        fail_count++;
    end

    // It is released only when the last Cr row has left
    hold_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(rgb24_hold) |-> $past(di_valid && !di_hold && di_cnt == BLK_CR))
    else begin
        $error("rgb24_hold fell before the drain was complete");
        fail_count++;
    end

endmodule

bind jisp jisp_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .di             (di),
    .di_valid       (di_valid),
    .di_hold        (di_hold),
    .di_cnt         (di_cnt),
    .rgb24_hold     (rgb24_hold),
    .frame_valid_in (frame_valid_in),
    .x_size_m1      (x_size_m1),
    .y_size_m1      (y_size_m1),
    .pix_valid      (yuv420_s.valid[0]),
    .pix_x          (yuv420_s.pixel_count),
    .pix_y          (yuv420_s.line_count)
);

// File: test/jisp_tb.sv
`timescale 1ns/1ps

module jisp_tb import jisp_pkg::*; ();

    localparam int PAT_CONST = 0;
    localparam int PAT_RAMP  = 1;
    localparam int PAT_RAND  = 2;
    localparam int NUM_CASES = 6;

    typedef struct {
        int w;
        int h;
        int kind;
        int gap_pct;
        int hold_pct;
        int frames;
        int rows;
    } case_t;

    // Width, height, pattern, gap and hold chance in percent, frames, expected rows
    case_t cases [NUM_CASES] = '{
        '{16, 16, PAT_CONST, 0,  0,  1, 48},
        '{32, 16, PAT_RAMP,  0,  0,  1, 96},
        '{16, 32, PAT_RAND,  0,  0,  1, 96},
        '{32, 32, PAT_RAND,  0,  50, 1, 192},
        '{64, 16, PAT_RAMP,  30, 20, 2, 384},
        '{64, 64, PAT_RAND,  20, 30, 1, 768}
    };

    logic             clk = 1'b0;
    logic             rst;
    logic [DW-1:0]    rgb24 [2:0];
    logic             rgb24_valid;
    logic             rgb24_hold;
    logic             frame_valid_in;
    logic [DW-1:0]    di [7:0];
    logic             di_valid;
    logic             di_hold;
    blk_e             di_cnt;
    logic [XW-1:0]    x_size_m1;
    logic [YW-1:0]    y_size_m1;

    int               seed = 32'h457f_c5c4;
    int               err_cnt = 0;
    int               rx_cnt = 0;
    int               cycles = 0;
    int               limit = 1000;
    logic [23:0]      img [0:MAX_X*MAX_Y-1];
    logic [8*BLK-1:0] exp_row [$];
    logic [2:0]       exp_tag [$];

    jisp u_dut (.*);

    always #5 clk = ~clk;

    // ##############################
    // Reference model
    // ##############################

    function automatic int clamp255(input int v);
        if (v < 0)
            return 0;
        return (v > 255) ? 255 : v;
    endfunction

    // Component 0 is Y, 1 is Cb, 2 is Cr
    function automatic int to_ycc(input logic [23:0] p, input int comp);
        int r;
        int g;
        int b;
        r = p[23:16];
        g = p[15:8];
        b = p[7:0];
        case (comp)
            0: return clamp255((CY_R * r + CY_G * g + CY_B * b + 128) >>> 8);
            1: return clamp255(((CB_B * b - CB_R * r - CB_G * g + 128) >>> 8) + CHROMA_OFS);
            default: return clamp255(((CR_R * r - CR_G * g - CR_B * b + 128) >>> 8) + CHROMA_OFS);
        endcase
    endfunction

    function automatic logic chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    task automatic make_frame(input int c, input int f);
        for (int y = 0; y < cases[c].h; y++) begin
            for (int x = 0; x < cases[c].w; x++) begin
                case (cases[c].kind)
                    PAT_CONST: img[y*MAX_X+x] = 24'hc8_3c_1e;
                    PAT_RAMP:  img[y*MAX_X+x] = {8'(x*4+y), 8'(y*4+f*40), 8'(255-x*3-y)};
                    default:   img[y*MAX_X+x] = 24'($random(seed));
                endcase
            end
        end
    endtask

    // MCU order per stripe: four luma quadrants, then Cb and Cr from even-line pairs
    task automatic expect_frame(input int c);
        logic [8*BLK-1:0] row;
        int               ln;
        int               px;
        for (int s = 0; s < cases[c].h / MCU_W; s++)
            for (int m = 0; m < cases[c].w / MCU_W; m++)
                for (int b = 0; b < 6; b++)
                    for (int r = 0; r < BLK; r++) begin
                        for (int k = 0; k < BLK; k++) begin
                            if (b < 4) begin
                                ln = s*MCU_W + (b/2)*BLK + r;
                                px = m*MCU_W + (b%2)*BLK + k;
                                row[8*k +: 8] = 8'(to_ycc(img[ln*MAX_X+px], 0));
                            end else begin
                                ln = s*MCU_W + 2*r;
                                px = m*MCU_W + 2*k;
                                row[8*k +: 8] = 8'((to_ycc(img[ln*MAX_X+px], b-3) +
                                    to_ycc(img[ln*MAX_X+px+1], b-3) + 1) >> 1);
                            end
                        end
                        exp_row.push_back(row);
                        exp_tag.push_back(3'(b));
                    end
    endtask

    // ##############################
    // Stimulus
    // ##############################

    task automatic tick(input int hold_pct);
        @(posedge clk);
        di_hold <= chance(hold_pct);
    endtask

    task automatic drive_frame(input int c);
        int idx;
        int n;
        int a;
        idx = 0;
        n = cases[c].w * cases[c].h;
        while (idx < n) begin
            tick(cases[c].hold_pct);
            if (rgb24_valid && !rgb24_hold)
                idx++;
            // A pixel offered under hold stays on the bus until it is taken
            if (!(rgb24_valid && rgb24_hold)) begin
                if (idx < n && !chance(cases[c].gap_pct)) begin
                    a = (idx / cases[c].w) * MAX_X + idx % cases[c].w;
                    rgb24[0]    <= img[a][23:16];
                    rgb24[1]    <= img[a][15:8];
                    rgb24[2]    <= img[a][7:0];
                    rgb24_valid <= 1'b1;
                end else begin
                    rgb24_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic run_case(input int c);
        rx_cnt = 0;
        tick(0);
        x_size_m1      <= XW'(cases[c].w - 1);
        y_size_m1      <= YW'(cases[c].h - 1);
        frame_valid_in <= 1'b1;
        // Frames of one case follow each other with frame_valid kept high
        for (int f = 0; f < cases[c].frames; f++) begin
            make_frame(c, f);
            expect_frame(c);
            drive_frame(c);
        end
        // The queue is looked at between edges, after the scoreboard has popped
        @(negedge clk);
        while (exp_row.size() != 0) begin
            tick(cases[c].hold_pct);
            @(negedge clk);
        end
        tick(0);
        frame_valid_in <= 1'b0;
        repeat (4) tick(0);
        if (rx_cnt != cases[c].rows) begin
            $display("error at %0t: case %0d gave %0d rows, expected %0d",
                     $time, c, rx_cnt, cases[c].rows);
            err_cnt++;
        end
    endtask

    // ##############################
    // Scoreboard and watchdog
    // ##############################

    always @(posedge clk) begin
        logic [8*BLK-1:0] got;
        logic [8*BLK-1:0] want;
        logic [2:0]       want_tag;
        if (!rst && di_valid && !di_hold) begin
            for (int k = 0; k < BLK; k++)
                got[8*k +: 8] = di[k];
            if (exp_row.size() == 0) begin
                $display("An output row arrived at %0t when no row was expected", $time);
                err_cnt++;
            end else begin
                want     = exp_row.pop_front();
                want_tag = exp_tag.pop_front();
                if (got !== want || di_cnt !== want_tag) begin
                    $display("error at %0t: row %0d expected %h tag %0d, got %h tag %0d",
                             $time, rx_cnt, want, want_tag, got, di_cnt);
                    err_cnt++;
                end
            end
            rx_cnt++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst            = 1'b1;
        rgb24          = '{8'd0, 8'd0, 8'd0};
        rgb24_valid    = 1'b0;
        frame_valid_in = 1'b0;
        di_hold        = 1'b0;
        x_size_m1      = '1;
        y_size_m1      = '1;
        for (int c = 0; c < NUM_CASES; c++)
            limit += 4 * cases[c].frames * cases[c].w * cases[c].h + cases[c].rows;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int c = 0; c < NUM_CASES; c++)
            run_case(c);
        $display("Errors: %0d row checks, %0d assertions", err_cnt, u_dut.u_checker.fail_count);
        if (err_cnt == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: jisp.f
hdl/jisp_pkg.sv
hdl/pixel_stream_if.sv
hdl/rgb2yuv.sv
hdl/subsample.sv
hdl/mcu_buffer.sv
hdl/jisp.sv
test/jisp_checker.sv
test/jisp_tb.sv

// File: Bender.yml
package:
  name: jisp

sources:
  - hdl/jisp_pkg.sv
  - hdl/pixel_stream_if.sv
  - hdl/rgb2yuv.sv
  - hdl/subsample.sv
  - hdl/mcu_buffer.sv
  - hdl/jisp.sv
  - target: test
    files:
      - test/jisp_checker.sv
      - test/jisp_tb.sv
